// ==== lcd_video_pkg.sv ====
// shared constants, contrast table, screen colours and bus structs for the LCD video path
// imported by every module of the display pipeline

package lcd_video_pkg;

    ////////////////////////////////////////////////////////////
    // LCD and frame buffer geometry
    localparam int LCD_XSIZE = 96;
    localparam int LCD_YSIZE = 64;
    localparam int LCD_PAGES = 8;      // 8-pixel column bytes per x
    localparam int FB_DEPTH  = 768;
    localparam int NUM_BANKS = 4;

    ////////////////////////////////////////////////////////////
    // raster, 1x image centred
    localparam int H_TOTAL       = 407;
    localparam int V_TOTAL       = 262;
    localparam int H_START       = 155;
    localparam int V_START       = 99;
    localparam int HS_START      = 383;
    localparam int HS_WIDTH      = 24;
    localparam int VS_FIRST_LINE = 1;
    localparam int VS_LAST_LINE  = 3;
    localparam int PIX_DIV       = 5;  // clk_sys cycles per pixel

    typedef logic [1:0] bank_idx_t;
    typedef logic [5:0] contrast_t;
    typedef logic [9:0] fb_addr_t;

    typedef struct packed {
        fb_addr_t   addr;
        logic [7:0] data;
        contrast_t  contrast;
    } fb_write_t;

    typedef struct packed {
        logic [7:0] data;
        contrast_t  contrast;
    } bank_read_t;

    typedef struct packed {
        logic       active;
        logic [6:0] x;
        logic [5:0] y;
    } pix_pos_t;

    typedef struct packed {
        logic hs;
        logic vs;
        logic hblank;
        logic vblank;
    } sync_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        rgb_t  rgb;
        sync_t sync;
        logic  de;
    } video_out_t;

    localparam sync_t SYNC_IDLE = '{hs: 1'b0, vs: 1'b0, hblank: 1'b1, vblank: 1'b1};

    localparam rgb_t OFF_COLOR = '{r: 8'hB7, g: 8'hCA, b: 8'hB7};  // clear pixel
    localparam rgb_t ON_COLOR  = '{r: 8'h04, g: 8'h16, b: 8'h04};  // fully dark

    // light / dark shade per contrast code, index is {contrast, pixel}
    localparam logic [7:0] CONTRAST_MAP [128] = '{
          8'd0,   8'd4,    8'd0,   8'd4,    8'd0,   8'd4,    8'd0,   8'd4,   // 00-03
          8'd0,   8'd6,    8'd0,  8'd11,    8'd0,  8'd17,    8'd0,  8'd24,   // 04-07
          8'd0,  8'd31,    8'd0,  8'd40,    8'd0,  8'd48,    8'd0,  8'd57,   // 08-0b
          8'd0,  8'd67,    8'd0,  8'd77,    8'd0,  8'd88,    8'd0,  8'd99,   // 0c-0f
          8'd0, 8'd110,    8'd0, 8'd122,    8'd0, 8'd133,    8'd0, 8'd146,   // 10-13
          8'd0, 8'd158,    8'd0, 8'd171,    8'd0, 8'd184,    8'd0, 8'd198,   // 14-17
          8'd0, 8'd212,    8'd0, 8'd226,    8'd0, 8'd240,    8'd0, 8'd255,   // 18-1b
          8'd2, 8'd255,    8'd5, 8'd255,   8'd10, 8'd255,   8'd15, 8'd255,   // 1c-1f
         8'd21, 8'd255,   8'd27, 8'd255,   8'd34, 8'd255,   8'd41, 8'd255,   // 20-23
         8'd48, 8'd255,   8'd56, 8'd255,   8'd64, 8'd255,   8'd73, 8'd255,   // 24-27
         8'd81, 8'd255,   8'd90, 8'd255,  8'd100, 8'd255,  8'd109, 8'd255,   // 28-2b
        8'd119, 8'd255,  8'd129, 8'd255,  8'd139, 8'd255,  8'd149, 8'd255,   // 2c-2f
        8'd160, 8'd255,  8'd171, 8'd255,  8'd182, 8'd255,  8'd193, 8'd255,   // 30-33
        8'd204, 8'd255,  8'd216, 8'd255,  8'd228, 8'd255,  8'd240, 8'd255,   // 34-37
        8'd240, 8'd255,  8'd240, 8'd255,  8'd240, 8'd255,  8'd240, 8'd255,   // 38-3b
        8'd240, 8'd255,  8'd240, 8'd255,  8'd240, 8'd255,  8'd240, 8'd255    // 3c-3f
    };

    // bank address of a column byte, page major
    function automatic fb_addr_t fb_addr(input logic [2:0] page, input logic [6:0] x);
        return fb_addr_t'(page) * fb_addr_t'(LCD_XSIZE) + fb_addr_t'(x);
    endfunction

endpackage

// ==== lcd_frame_capture.sv ====
// copies a finished LCD frame into the next bank of the frame ring
// walks the LCD read port after each frame_complete and publishes the bank when done

`timescale 1ns/1ps

module lcd_frame_capture import lcd_video_pkg::*;
(
    input  logic                 clk_sys,
    input  logic                 reset,
    input  logic                 frame_complete,
    input  contrast_t            lcd_contrast,
    input  logic [7:0]           lcd_read_column,
    output logic [6:0]           lcd_read_x,
    output logic [2:0]           lcd_read_y,
    output fb_write_t            wr,
    output logic [NUM_BANKS-1:0] wr_en,
    output bank_idx_t            read_bank
);

    logic       busy;          // address walk running
    logic       pending;       // frame seen during a walk
    logic [6:0] x_cnt;
    logic [2:0] page_cnt;
    logic       x_last;
    logic       walk_last;
    bank_idx_t  wr_idx;        // bank being filled
    logic       wr_valid;
    logic       wr_last;
    fb_addr_t   wr_addr_q;
    contrast_t  wr_contrast_q;

    assign x_last    = (x_cnt == 7'(LCD_XSIZE - 1));
    assign walk_last = busy && x_last && (page_cnt == 3'(LCD_PAGES - 1));

    assign lcd_read_x = x_cnt;
    assign lcd_read_y = page_cnt;

    ////////////////////////////////////////////////////////////
    // capture walk, x fastest
    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            busy      <= 1'b0;
            pending   <= 1'b0;
            x_cnt     <= '0;
            page_cnt  <= '0;
            wr_idx    <= 2'd1;
            read_bank <= '0;
            wr_valid  <= 1'b0;
            wr_last   <= 1'b0;
        end
        else
        begin
            wr_valid <= busy;       // column arrives one cycle later
            wr_last  <= walk_last;

            if (busy)
            begin
                x_cnt <= x_last ? 7'd0 : x_cnt + 7'd1;
                if (x_last)
                    page_cnt <= page_cnt + 3'd1;   // wraps to 0 after last page

                if (walk_last)
                begin
                    busy    <= pending | frame_complete;  // back to back capture
                    pending <= 1'b0;
                end
                else if (frame_complete)
                    pending <= 1'b1;
            end
            else if (frame_complete)
                busy <= 1'b1;

            // last byte written this cycle, publish the bank
            if (wr_last)
            begin
                read_bank <= wr_idx;
                wr_idx    <= wr_idx + 2'd1;
            end
        end
    end

    always_ff @(posedge clk_sys)
    begin
        wr_addr_q     <= fb_addr(page_cnt, x_cnt);
        wr_contrast_q <= lcd_contrast;     // contrast current when read
    end

    assign wr = '{addr: wr_addr_q, data: lcd_read_column, contrast: wr_contrast_q};

    always_comb
    begin
        wr_en = '0;
        if (wr_valid)
            wr_en[wr_idx] = 1'b1;
    end

endmodule

// ==== lcd_frame_bank.sv ====
// one bank of the frame ring, 768 column bytes plus the contrast of its frame
// registered read, data one cycle after rd_addr

`timescale 1ns/1ps

module lcd_frame_bank import lcd_video_pkg::*;
(
    input  logic       clk_sys,
    input  fb_write_t  wr,
    input  logic       wr_en,
    input  fb_addr_t   rd_addr,
    output bank_read_t rd
);

    logic [7:0] mem [FB_DEPTH];
    contrast_t  contrast_q;   // contrast of the frame held here

    always_ff @(posedge clk_sys)
    begin
        if (wr_en)
        begin
            mem[wr.addr] <= wr.data;
            contrast_q   <= wr.contrast;
        end
    end

    // read side
    always_ff @(posedge clk_sys)
    begin
        rd.data     <= mem[rd_addr];
        rd.contrast <= contrast_q;
    end

endmodule

// ==== lcd_shade_blend.sv ====
// looks up each bank's pixel, maps it through the contrast table to a shade
// and either selects the newest frame or averages all four

`timescale 1ns/1ps

module lcd_shade_blend import lcd_video_pkg::*;
(
    input  logic       clk_sys,
    input  logic       reset,
    input  pix_pos_t   pos,
    input  sync_t      sync,
    input  logic       blend_mode,
    input  bank_idx_t  read_bank,
    input  bank_read_t bank_rd [NUM_BANKS],
    output fb_addr_t   rd_addr,
    output logic [7:0] shade,
    output pix_pos_t   pos_d,
    output sync_t      sync_d
);

    pix_pos_t   pos_q;                    // lines up with bank data
    sync_t      sync_q;
    logic [7:0] bank_shade [NUM_BANKS];
    logic [9:0] shade_sum;

    // clear bit takes the light entry, set bit the dark one
    function automatic logic [7:0] map_bit(input logic px, input contrast_t contrast);
        return CONTRAST_MAP[{contrast, px}];
    endfunction

    assign rd_addr = fb_addr(pos.y[5:3], pos.x);

    always_comb
    begin
        shade_sum = '0;
        for (int i = 0; i < NUM_BANKS; i++)
        begin
            bank_shade[i] = map_bit(bank_rd[i].data[pos_q.y[2:0]], bank_rd[i].contrast);
            shade_sum     = shade_sum + 10'(bank_shade[i]);
        end
    end

    ////////////////////////////////////////////////////////////
    // position and sync follow the 2 cycle shade path
    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            pos_q  <= '0;
            sync_q <= SYNC_IDLE;
            pos_d  <= '0;
            sync_d <= SYNC_IDLE;
        end
        else
        begin
            pos_q  <= pos;
            sync_q <= sync;
            pos_d  <= pos_q;
            sync_d <= sync_q;
        end
    end

    always_ff @(posedge clk_sys)
    begin
        if (blend_mode)
            shade <= 8'(shade_sum / NUM_BANKS);   // fraction dropped
        else
            shade <= bank_shade[read_bank];
    end

endmodule

// ==== lcd_video_timing.sv ====
// pixel enable and 407x262 raster with the 96x64 LCD window centred
// gives the LCD pixel position for each raster point

`timescale 1ns/1ps

module lcd_video_timing import lcd_video_pkg::*;
(
    input  logic     clk_sys,
    input  logic     reset,
    output logic     ce_pix,
    output pix_pos_t pos,
    output sync_t    sync
);

    logic [2:0] div_cnt;
    logic [8:0] h_cnt;
    logic [8:0] v_cnt;
    logic       h_last;
    logic       hblank;
    logic       vblank;
    logic       hs;
    logic       vs;

    assign ce_pix = (div_cnt == 3'(PIX_DIV - 1));
    assign h_last = (h_cnt == 9'(H_TOTAL - 1));

    ////////////////////////////////////////////////////////////
    // divider and raster counters
    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            div_cnt <= '0;
            h_cnt   <= '0;
            v_cnt   <= '0;
        end
        else
        begin
            div_cnt <= ce_pix ? 3'd0 : div_cnt + 3'd1;

            if (ce_pix)
            begin
                h_cnt <= h_last ? 9'd0 : h_cnt + 9'd1;
                if (h_last)
                begin
                    if (v_cnt == 9'(V_TOTAL - 1))
                        v_cnt <= '0;
                    else
                        v_cnt <= v_cnt + 9'd1;
                end
            end
        end
    end

    // decode from the counters
    assign hblank = (h_cnt < 9'(H_START)) || (h_cnt >= 9'(H_START + LCD_XSIZE));
    assign vblank = (v_cnt < 9'(V_START)) || (v_cnt >= 9'(V_START + LCD_YSIZE));

    assign hs = (h_cnt >= 9'(HS_START)) && (h_cnt < 9'(HS_START + HS_WIDTH));
    assign vs = (v_cnt >= 9'(VS_FIRST_LINE)) && (v_cnt <= 9'(VS_LAST_LINE));  // whole lines

    assign sync = '{hs: hs, vs: vs, hblank: hblank, vblank: vblank};

    // position inside the window, only meaningful when active
    assign pos.active = !hblank && !vblank;
    assign pos.x      = 7'(h_cnt - 9'(H_START));
    assign pos.y      = 6'(v_cnt - 9'(V_START));

endmodule

// ==== lcd_color_tint.sv ====
// tints the shade between the screen's off and on colours
// registers RGB together with sync and de

`timescale 1ns/1ps

module lcd_color_tint import lcd_video_pkg::*;
(
    input  logic       clk_sys,
    input  logic       reset,
    input  logic [7:0] shade,
    input  pix_pos_t   pos_d,
    input  sync_t      sync_d,
    output video_out_t video
);

    // ((255 - shade) * off + shade * on) / 255
    function automatic logic [7:0] tint(input logic [7:0] level, input logic [7:0] off_c,
                                        input logic [7:0] on_c);
        logic [15:0] mix;
        mix = 16'(8'd255 - level) * 16'(off_c) + 16'(level) * 16'(on_c);
        return 8'(mix / 16'd255);
    endfunction

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            video.rgb  <= '0;
            video.sync <= SYNC_IDLE;
            video.de   <= 1'b0;
        end
        else
        begin
            video.sync <= sync_d;
            video.de   <= pos_d.active;
            if (pos_d.active)
            begin
                video.rgb.r <= tint(shade, OFF_COLOR.r, ON_COLOR.r);
                video.rgb.g <= tint(shade, OFF_COLOR.g, ON_COLOR.g);
                video.rgb.b <= tint(shade, OFF_COLOR.b, ON_COLOR.b);
            end
            else
                video.rgb <= '0;     // black border
        end
    end

endmodule

// ==== lcd_video_top.sv ====
// LCD display path top, frame capture into a 4 bank ring, shade blend and raster out
// RGB for a raster point appears 3 cycles after its ce_pix

`timescale 1ns/1ps

module lcd_video_top import lcd_video_pkg::*;
(
    input  logic       clk_sys,
    input  logic       reset,
    input  logic       frame_complete,
    input  contrast_t  lcd_contrast,
    input  logic [7:0] lcd_read_column,
    input  logic       blend_mode,
    output logic [6:0] lcd_read_x,
    output logic [2:0] lcd_read_y,
    output logic       ce_pix,
    output video_out_t video
);

    fb_write_t            wr;
    logic [NUM_BANKS-1:0] wr_en;
    bank_idx_t            read_bank;
    fb_addr_t             rd_addr;
    bank_read_t           bank_rd [NUM_BANKS];
    pix_pos_t             pos;
    sync_t                sync;
    logic [7:0]           shade;
    pix_pos_t             pos_d;
    sync_t                sync_d;

    lcd_frame_capture u_capture (
        .clk_sys(clk_sys), .reset(reset), .frame_complete(frame_complete),
        .lcd_contrast(lcd_contrast), .lcd_read_column(lcd_read_column),
        .lcd_read_x(lcd_read_x), .lcd_read_y(lcd_read_y),
        .wr(wr), .wr_en(wr_en), .read_bank(read_bank)
    );

    // frame ring
    for (genvar i = 0; i < NUM_BANKS; i++)
    begin : g_bank
        lcd_frame_bank u_bank (
            .clk_sys(clk_sys), .wr(wr), .wr_en(wr_en[i]),
            .rd_addr(rd_addr), .rd(bank_rd[i])
        );
    end

    lcd_video_timing u_timing (
        .clk_sys(clk_sys), .reset(reset), .ce_pix(ce_pix), .pos(pos), .sync(sync)
    );

    lcd_shade_blend u_blend (
        .clk_sys(clk_sys), .reset(reset), .pos(pos), .sync(sync),
        .blend_mode(blend_mode), .read_bank(read_bank), .bank_rd(bank_rd),
        .rd_addr(rd_addr), .shade(shade), .pos_d(pos_d), .sync_d(sync_d)
    );

    lcd_color_tint u_tint (
        .clk_sys(clk_sys), .reset(reset), .shade(shade),
        .pos_d(pos_d), .sync_d(sync_d), .video(video)
    );

endmodule

// ==== tb_lcd_video.sv ====
// testbench for the LCD video path that captures table driven frames and checks every pixel
// against a reference model of the contrast map, frame blend and colour tint

`timescale 1ns/1ps

module tb_lcd_video import lcd_video_pkg::*;
();

    localparam int NUM_ROWS       = 4;
    localparam int FRAME_CYCLES   = 533170;   // 407 x 262 pixels of 5 cycles
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 3 * FRAME_CYCLES + RESET_CYCLES;
    localparam int EXP_DE_COUNT   = 96 * 64;
    localparam int EXP_LINES      = 262;
    localparam int EXP_HS_WIDTH   = 24;

    typedef struct packed {
        contrast_t   contrast;
        logic        blend;
        logic [31:0] seed;
    } row_t;

    logic       clk_sys;
    logic       reset;
    logic       frame_complete;
    contrast_t  lcd_contrast;
    logic [7:0] lcd_read_column;
    logic       blend_mode;
    logic [6:0] lcd_read_x;
    logic [2:0] lcd_read_y;
    logic       ce_pix;
    video_out_t video;

    row_t       rows [NUM_ROWS];
    string      row_names [NUM_ROWS];
    logic [7:0] lcd_img [FB_DEPTH];                // behavioural LCD memory
    logic [7:0] ref_img [NUM_BANKS * FB_DEPTH];    // last four captured frames
    contrast_t  ref_con [NUM_BANKS];
    int         ring_wr;
    int         newest;
    video_out_t cur;                               // last sampled pixel
    logic       prev_vs;
    logic       prev_hs;
    int         cycle_cnt;

    lcd_video_top u_dut (
        .clk_sys(clk_sys), .reset(reset), .frame_complete(frame_complete),
        .lcd_contrast(lcd_contrast), .lcd_read_column(lcd_read_column),
        .blend_mode(blend_mode), .lcd_read_x(lcd_read_x), .lcd_read_y(lcd_read_y),
        .ce_pix(ce_pix), .video(video)
    );

    initial
    begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    // LCD answers one cycle after the address
    always @(posedge clk_sys)
        lcd_read_column <= lcd_img[int'(lcd_read_y) * LCD_XSIZE + int'(lcd_read_x)];

    always @(posedge clk_sys)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycle_cnt);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////////////////////////
    // compare tasks
    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp)
        begin
            $display("** Error: %s expected %h actual %h", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "rgb mismatch");
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act !== exp)
        begin
            $display("** Error: %s expected %0d actual %0d", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic check_sync(input string name, input sync_t exp, input sync_t act);
        if (act !== exp)
        begin
            $display("** Error: %s expected %b actual %b", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "sync mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    function automatic logic [7:0] ref_shade(input int k, input int x, input int y);
        logic [7:0] col;
        logic       px;
        col = ref_img[k * FB_DEPTH + (y / 8) * LCD_XSIZE + x];
        px  = col[y % 8];
        return CONTRAST_MAP[2 * int'(ref_con[k]) + int'(px)];   // light entry first
    endfunction

    function automatic logic [7:0] mix_channel(input int s, input int off_c, input int on_c);
        return 8'(((255 - s) * off_c + s * on_c) / 255);
    endfunction

    function automatic rgb_t expected_rgb(input int x, input int y, input logic blend);
        int   s;
        rgb_t c;
        s = 0;
        if (blend)
        begin
            for (int k = 0; k < NUM_BANKS; k++)
                s = s + int'(ref_shade(k, x, y));
            s = s / NUM_BANKS;                     // fraction dropped
        end
        else
            s = int'(ref_shade(newest, x, y));
        c.r = mix_channel(s, int'(OFF_COLOR.r), int'(ON_COLOR.r));
        c.g = mix_channel(s, int'(OFF_COLOR.g), int'(ON_COLOR.g));
        c.b = mix_channel(s, int'(OFF_COLOR.b), int'(ON_COLOR.b));
        return c;
    endfunction

    task automatic load_table();
        rows[0] = '{contrast: 6'd32, blend: 1'b0, seed: 32'h3c1f_77a2};
        rows[1] = '{contrast: 6'd0,  blend: 1'b0, seed: 32'h0b54_e019};
        rows[2] = '{contrast: 6'd63, blend: 1'b0, seed: 32'h91d0_4c6e};
        rows[3] = '{contrast: 6'd45, blend: 1'b1, seed: 32'h5a2e_b3f1};  // blends rows 0 to 3
        row_names[0] = "mid_contrast";
        row_names[1] = "contrast_min";
        row_names[2] = "contrast_max";
        row_names[3] = "blend_four";
    endtask

    // new LCD image kept in the reference ring too
    task automatic fill_image(input logic [31:0] seed, input contrast_t contrast);
        logic [31:0] tmp;
        for (int a = 0; a < FB_DEPTH; a++)
        begin
            tmp        = $urandom ^ (seed * (a + 1));
            lcd_img[a] = tmp[7:0] ^ tmp[15:8] ^ tmp[23:16] ^ tmp[31:24];
            ref_img[ring_wr * FB_DEPTH + a] = lcd_img[a];
        end
        ref_con[ring_wr] = contrast;
        newest  = ring_wr;
        ring_wr = (ring_wr + 1) % NUM_BANKS;
    endtask

    // sample video on the edge that ends a ce_pix cycle
    task automatic next_pixel();
        prev_vs = cur.sync.vs;
        prev_hs = cur.sync.hs;
        @(posedge clk_sys);
        while (!ce_pix)
            @(posedge clk_sys);
        cur = video;
    endtask

    task automatic wait_vs_rise();
        next_pixel();
        while (!(cur.sync.vs && !prev_vs))
            next_pixel();
    endtask

    ////////////////////////////////////////////////////////////
    // one full frame from vs rise to vs rise
    task automatic check_frame(input int r);
        int    de_cnt;
        int    hs_pulses;
        int    hs_len;
        int    h_pos;
        int    v_pos;
        sync_t exp_sync;
        logic  done;
        string name;
        de_cnt    = 0;
        hs_pulses = 0;
        hs_len    = 0;
        h_pos     = 0;
        v_pos     = VS_FIRST_LINE;    // vs rises at the start of its first line
        done      = 1'b0;
        name      = row_names[r];
        while (!done)
        begin
            next_pixel();
            if (h_pos == H_TOTAL - 1)
            begin
                h_pos = 0;
                v_pos = (v_pos + 1) % V_TOTAL;
            end
            else
                h_pos++;

            // raster position decoded from the timing rules
            exp_sync.hs     = (h_pos >= HS_START) && (h_pos < HS_START + HS_WIDTH);
            exp_sync.vs     = (v_pos >= VS_FIRST_LINE) && (v_pos <= VS_LAST_LINE);
            exp_sync.hblank = (h_pos < H_START) || (h_pos >= H_START + LCD_XSIZE);
            exp_sync.vblank = (v_pos < V_START) || (v_pos >= V_START + LCD_YSIZE);
            check_sync($sformatf("%s sync h=%0d v=%0d", name, h_pos, v_pos),
                       exp_sync, cur.sync);
            check_count($sformatf("%s de h=%0d v=%0d", name, h_pos, v_pos),
                        int'(!exp_sync.hblank && !exp_sync.vblank), int'(cur.de));

            if (cur.sync.hs)
            begin
                if (!prev_hs)
                    hs_pulses++;
                hs_len++;
            end
            else if (prev_hs)
            begin
                check_count({name, " hs width"}, EXP_HS_WIDTH, hs_len);
                hs_len = 0;
            end
            if (cur.de)
            begin
                check_rgb($sformatf("%s pixel x=%0d y=%0d", name, de_cnt % 96, de_cnt / 96),
                          expected_rgb(de_cnt % 96, de_cnt / 96, rows[r].blend), cur.rgb);
                de_cnt++;
            end
            else
                check_rgb({name, " border"}, '0, cur.rgb);     // black outside window
            done = cur.sync.vs && !prev_vs;
        end
        check_count({name, " de strobes"}, EXP_DE_COUNT, de_cnt);
        check_count({name, " hs pulses"}, EXP_LINES, hs_pulses);
    endtask

    task automatic run_row(input int r);
        fill_image(rows[r].seed, rows[r].contrast);
        @(posedge clk_sys);
        lcd_contrast   <= rows[r].contrast;
        blend_mode     <= rows[r].blend;
        frame_complete <= 1'b1;
        @(posedge clk_sys);
        frame_complete <= 1'b0;
        wait_vs_rise();
        wait_vs_rise();     // capture long done by now
        check_frame(r);
    endtask

    initial
    begin
        int unsigned seed_state;
        int unsigned junk;
        reset           = 1'b1;
        frame_complete  = 1'b0;
        lcd_contrast    = '0;
        blend_mode      = 1'b0;
        lcd_read_column = '0;
        cycle_cnt       = 0;
        ring_wr         = 0;
        newest          = 0;
        seed_state      = 32'haa058385;
        junk            = $urandom(seed_state);
        load_table();

        repeat (RESET_CYCLES) @(posedge clk_sys);
        reset <= 1'b0;
        @(posedge clk_sys);
        // outputs still in reset state before any ce_pix
        check_count("reset ce_pix", 0, int'(ce_pix));
        check_rgb("reset rgb", '0, video.rgb);
        check_count("reset de", 0, int'(video.de));
        check_sync("reset sync", '{hs: 1'b0, vs: 1'b0, hblank: 1'b1, vblank: 1'b1}, video.sync);
        cur = video;

        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== build.f ====
lcd_video_pkg.sv
lcd_frame_capture.sv
lcd_frame_bank.sv
lcd_shade_blend.sv
lcd_video_timing.sv
lcd_color_tint.sv
lcd_video_top.sv
tb_lcd_video.sv
